//--- build.sh
#!/bin/sh
# Compile the data-memory testbench with Verilator and run it.
# Exit status is nonzero when the build fails, the run fails or the log
# reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module dmem_tb \
	-Mdir "$OBJ" -o dmem_sim -f dmem.f
if [ $? -ne 0 ]; then
	echo "build: Verilator compile failed"
	exit 1
fi

"./$OBJ/dmem_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "build: simulation exited with status $run_status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	echo "build: simulation reported a failure"
	exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
	echo "build: simulation ended without a result"
	exit 1
fi
exit 0

//--- dmem.f
src/dmem_pkg.sv
src/data_mem.sv
src/lsu.sv
src/dmem_regs.sv
src/dmem_top.sv
sim/dmem_tb.sv

//--- sim/dmem_tb.sv
/*
 * Testbench for the data-memory subsystem.
 * Drives four-phase accesses on the processor and register ports and
 * compares responses with a byte-array reference model.
 */
`timescale 1ns/1ns
`default_nettype none

module dmem_tb import dmem_pkg::*; ();

	localparam int MEM_WORDS = 256;
	localparam int MEM_BYTES = MEM_WORDS * 4;
	localparam int TIMEOUT = 20;

	logic clk, i_arst_n, i_req, i_we, i_unsigned, i_reg_req, i_reg_we;
	acc_size_t i_size;
	addr_t i_addr;
	word_t i_wdata, i_reg_wdata, o_rdata, o_reg_rdata;
	reg_sel_t i_reg_sel;
	logic o_ack, o_fault, o_reg_ack;

	// Reference model state
	logic [7:0] ref_mem [0:1023];
	addr_t prot_model, last_fault_model;
	int fault_model;
	// Expected response of the access in flight
	logic exp_fault, exp_data_valid;
	word_t exp_rdata;
	string cur_test;
	int err_cnt, test_err_base, tests_ok, tests_bad, i;
	integer seed;
	addr_t rand_addr [8];
	word_t rd;

	dmem_top #(.MEM_WORDS(MEM_WORDS)) dut0 (
		.clk(clk), .i_arst_n(i_arst_n), .i_req(i_req), .i_we(i_we), .i_size(i_size),
		.i_unsigned(i_unsigned), .i_addr(i_addr), .i_wdata(i_wdata),
		.i_reg_req(i_reg_req), .i_reg_we(i_reg_we), .i_reg_sel(i_reg_sel),
		.i_reg_wdata(i_reg_wdata), .o_ack(o_ack), .o_fault(o_fault), .o_rdata(o_rdata),
		.o_reg_ack(o_reg_ack), .o_reg_rdata(o_reg_rdata)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Response must match the model for as long as the ack is held
	a_rdata_match: assert property (@(posedge clk) disable iff (!i_arst_n)
		(o_ack && exp_data_valid) |-> (o_rdata == exp_rdata))
	else begin
		err_cnt++;
		$display("error %s: o_rdata expected %h actual %h",
			cur_test, exp_rdata, $sampled(o_rdata));
	end
	a_fault_match: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_ack |-> (o_fault == exp_fault))
	else begin
		err_cnt++;
		$display("error %s: o_fault expected %b actual %b",
			cur_test, exp_fault, $sampled(o_fault));
	end
	// Handshake order on both ports
	// The request may drop right after the ack is seen, so the rise is
	// checked against the request on the edge that raised the ack
	a_ack_after_req: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(o_ack) |-> $past(i_req))
	else begin
		err_cnt++;
		$display("o_ack rose without a request in test %s", cur_test);
	end
	a_ack_after_drop: assert property (@(posedge clk) disable iff (!i_arst_n)
		$fell(o_ack) |-> !$past(i_req))
	else begin
		err_cnt++;
		$display("o_ack fell while the request was still high in test %s", cur_test);
	end
	a_reg_ack_after_req: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(o_reg_ack) |-> $past(i_reg_req))
	else begin
		err_cnt++;
		$display("o_reg_ack rose without a request in test %s", cur_test);
	end

	// Access rules: alignment, range against the full 1 KiB, write protection
	function automatic logic access_faults(input logic we, input acc_size_t size,
		input addr_t addr);
		logic [63:0] end_addr;
		logic misaligned;
		end_addr = {32'd0, addr} + ((size == SIZE_BYTE) ? 64'd1 :
			(size == SIZE_HALF) ? 64'd2 : 64'd4);
		misaligned = (size == SIZE_HALF) ? addr[0] :
			(size == SIZE_WORD) ? (addr[1:0] != 2'b00) : 1'b0;
		return misaligned || (end_addr > 64'(MEM_BYTES)) ||
			(we && (addr < prot_model));
	endfunction

	// Little-endian load with sign or zero extension
	function automatic word_t model_load(input acc_size_t size, input logic uns, input addr_t addr);
		logic [9:0] idx;
		logic [15:0] half;
		idx = addr[9:0];
		half = {ref_mem[idx + 10'd1], ref_mem[idx]};
		if (size == SIZE_BYTE)
			return {{24{~uns & ref_mem[idx][7]}}, ref_mem[idx]};
		if (size == SIZE_HALF)
			return {{16{~uns & half[15]}}, half};
		return {ref_mem[idx + 10'd3], ref_mem[idx + 10'd2], half};
	endfunction

	task automatic model_store(input acc_size_t size, input addr_t addr, input word_t wdata);
		int n;
		n = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
		for (int b = 0; b < n; b++)
			ref_mem[addr[9:0] + 10'(b)] = wdata[b*8 +: 8];
	endtask

	task automatic abort_run(input string what);
		$display("%s in test %s", what, cur_test);
		$display("Checks failed");
		$finish;
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (o_ack !== level && cycles < TIMEOUT)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (o_ack !== level)
			abort_run($sformatf("timeout waiting for o_ack to become %b", level));
	endtask

	task automatic wait_reg_ack(input logic level);
		int cycles;
		cycles = 0;
		while (o_reg_ack !== level && cycles < TIMEOUT)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (o_reg_ack !== level)
			abort_run($sformatf("timeout waiting for o_reg_ack to become %b", level));
	endtask

	// One full four-phase access, with a random back-pressure hold
	task automatic mem_access(input logic we, input acc_size_t size, input logic uns,
		input addr_t addr, input word_t wdata);
		int hold;
		logic flt;
		wait_ack(1'b0);
		flt = access_faults(we, size, addr);
		exp_fault = flt;
		// Store data returned on the port carries no meaning unless refused
		exp_data_valid = !we || flt;
		exp_rdata = (flt || we) ? '0 : model_load(size, uns, addr);
		i_we = we;
		i_size = size;
		i_unsigned = uns;
		i_addr = addr;
		i_wdata = wdata;
		i_req = 1'b1;
		wait_ack(1'b1);
		hold = {$random(seed)} % 3;
		repeat (hold)
		begin
			@(posedge clk);
			#1;
		end
		i_req = 1'b0;
		wait_ack(1'b0);
		if (flt)
		begin
			fault_model++;
			last_fault_model = addr;
		end
		else if (we)
			model_store(size, addr, wdata);
	endtask

	task automatic reg_access(input logic we, input reg_sel_t sel, input word_t wdata,
		output word_t rdata);
		wait_reg_ack(1'b0);
		i_reg_we = we;
		i_reg_sel = sel;
		i_reg_wdata = wdata;
		i_reg_req = 1'b1;
		wait_reg_ack(1'b1);
		rdata = o_reg_rdata;
		i_reg_req = 1'b0;
		wait_reg_ack(1'b0);
		if (we && sel == REG_PROTECT)
			prot_model = wdata;
		if (we && sel == REG_FAULT_CNT)
			fault_model = 0;
	endtask

	task automatic check_value(input string what, input word_t exp, input word_t act);
		if (exp !== act)
		begin
			err_cnt++;
			$display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err_base = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_err_base)
		begin
			tests_ok++;
			$display("test %s: ok", cur_test);
		end
		else
		begin
			tests_bad++;
			$display("test %s: %0d errors", cur_test, err_cnt - test_err_base);
		end
	endtask

	initial
	begin
		seed = 32'hd0a32f0b;
		{i_arst_n, i_req, i_we, i_unsigned, i_reg_req, i_reg_we} = '0;
		i_size = SIZE_WORD;
		i_addr = '0;
		i_wdata = '0;
		i_reg_sel = REG_PROTECT;
		i_reg_wdata = '0;
		{err_cnt, tests_ok, tests_bad, fault_model} = '0;
		{prot_model, last_fault_model, exp_rdata} = '0;
		{exp_fault, exp_data_valid} = '0;
		begin_test("reset");
		repeat (8) @(posedge clk);
		#1 i_arst_n = 1'b1;

		// Idle outputs after reset, and no ack while the request is low
		begin_test("reset_and_handshake");
		check_value("o_ack", 32'd0, {31'd0, o_ack});
		check_value("o_fault", 32'd0, {31'd0, o_fault});
		check_value("o_reg_ack", 32'd0, {31'd0, o_reg_ack});
		repeat (3)
		begin
			@(posedge clk);
			#1 check_value("o_ack while idle", 32'd0, {31'd0, o_ack});
		end
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h0, $random(seed));
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'h0, '0);
		end_test();

		begin_test("word_store_readback");
		for (i = 0; i < 8; i++)
		begin
			rand_addr[i] = {$random(seed)} & 32'h3fc;
			mem_access(1'b1, SIZE_WORD, 1'b0, rand_addr[i], $random(seed));
		end
		for (i = 0; i < 8; i++)
			mem_access(1'b0, SIZE_WORD, 1'b0, rand_addr[i], '0);
		end_test();

		// Lane merge leaves 32'hbeef8044 at 0x100
		begin_test("byte_half_merge");
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h100, 32'h11223344);
		mem_access(1'b1, SIZE_BYTE, 1'b0, 32'h101, 32'hffffff80);
		mem_access(1'b1, SIZE_HALF, 1'b0, 32'h102, 32'h0000beef);
		for (i = 0; i < 8; i++)
			mem_access(1'b0, SIZE_BYTE, i[2], 32'h100 + (i & 3), '0);
		for (i = 0; i < 4; i++)
			mem_access(1'b0, SIZE_HALF, i[1], 32'h100 + ((i & 1) * 2), '0);
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'h100, '0);
		end_test();

		begin_test("fault_access");
		mem_access(1'b1, SIZE_HALF, 1'b0, 32'h101, 32'h0000dead);
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h102, 32'hdeadbeef);
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'h103, '0);
		mem_access(1'b0, SIZE_HALF, 1'b1, 32'h101, '0);
		mem_access(1'b0, SIZE_BYTE, 1'b0, 32'h400, '0);
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h400, 32'h12345678);
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'hfffffffc, '0);
		mem_access(1'b1, SIZE_HALF, 1'b0, 32'h3ff, 32'h0000aaaa);
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'h100, '0);
		// Word 0 is where the refused store at 0x400 would wrap to
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'h0, '0);
		end_test();

		// Protected stores are refused, loads below the boundary still work
		begin_test("write_protect");
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h20, 32'hcafe0020);
		reg_access(1'b1, REG_PROTECT, 32'd64, rd);
		reg_access(1'b0, REG_PROTECT, '0, rd);
		check_value("REG_PROTECT", 32'd64, rd);
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h20, 32'h55555555);
		mem_access(1'b1, SIZE_BYTE, 1'b0, 32'h3f, 32'h000000aa);
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'h20, '0);
		mem_access(1'b0, SIZE_HALF, 1'b0, 32'h22, '0);
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h40, 32'h87654321);
		mem_access(1'b0, SIZE_WORD, 1'b0, 32'h40, '0);
		end_test();

		begin_test("fault_registers");
		reg_access(1'b0, REG_FAULT_CNT, '0, rd);
		check_value("REG_FAULT_CNT", word_t'(fault_model), rd);
		reg_access(1'b0, REG_FAULT_ADDR, '0, rd);
		check_value("REG_FAULT_ADDR", last_fault_model, rd);
		// The last fault address is read-only
		reg_access(1'b1, REG_FAULT_ADDR, 32'h1234, rd);
		reg_access(1'b0, REG_FAULT_ADDR, '0, rd);
		check_value("REG_FAULT_ADDR after write", last_fault_model, rd);
		reg_access(1'b1, REG_FAULT_CNT, 32'h5, rd);
		reg_access(1'b0, REG_FAULT_CNT, '0, rd);
		check_value("REG_FAULT_CNT after clear", 32'd0, rd);
		mem_access(1'b1, SIZE_WORD, 1'b0, 32'h10, 32'h0badf00d);
		reg_access(1'b0, REG_FAULT_CNT, '0, rd);
		check_value("REG_FAULT_CNT after fault", word_t'(fault_model), rd);
		reg_access(1'b0, REG_FAULT_ADDR, '0, rd);
		check_value("REG_FAULT_ADDR after fault", 32'h10, rd);
		end_test();

		$display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/data_mem.sv
/*
 * Word-wide data memory.
 * Little-endian word array with one write enable per byte lane.
 * The read word is registered every cycle from the current index.
 */
`timescale 1ns/1ns
`default_nettype none

module data_mem import dmem_pkg::*; #(
	parameter int MEM_WORDS = 256
) (
	input  wire                         clk,
	input  byte_en_t                    i_we,
	input  wire [$clog2(MEM_WORDS)-1:0] i_addr,
	input  word_t                       i_wdata,
	output word_t                       o_rdata
);

	// Storage array, one entry per 32-bit word
	word_t mem [MEM_WORDS];

	// Each lane is written on its own enable so partial stores
	// leave the neighbouring bytes untouched
	always_ff @(posedge clk)
	begin
		for (int lane = 0; lane < 4; lane++)
		begin
			if (i_we[lane])
			begin
				mem[i_addr][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
			end
		end
	end

	// The read port follows the index every cycle
	// A store and a read of the same word in one cycle returns the old word
	always_ff @(posedge clk)
	begin
		o_rdata <= mem[i_addr];
	end

	// The load/store unit must never let an out-of-range write through
	// to the array, since the index would wrap onto a valid word
	a_we_in_range: assert property (
		@(posedge clk) (|i_we) |-> (int'(i_addr) < MEM_WORDS)
	) else $error("data_mem: write to index %0d beyond depth %0d", i_addr, MEM_WORDS);

endmodule

`default_nettype wire

//--- src/dmem_pkg.sv
/*
 * Shared types for the data-memory subsystem.
 * Holds the word, address and byte-enable types, the access size
 * and register select encodings, and the load/store FSM states.
 */
`default_nettype none

package dmem_pkg;

	// Data word as seen on the processor port and stored in memory
	typedef logic [31:0] word_t;

	// Byte address from the processor
	typedef logic [31:0] addr_t;

	// One write enable per byte lane, lane 0 is the lowest byte
	typedef logic [3:0] byte_en_t;

	// Width of a single access
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} acc_size_t;

	// Register select on the register port
	typedef logic [1:0] reg_sel_t;

	localparam reg_sel_t REG_PROTECT    = 2'd0;
	localparam reg_sel_t REG_FAULT_CNT  = 2'd1;
	localparam reg_sel_t REG_FAULT_ADDR = 2'd2;

	// Handshake states of the load/store unit
	typedef enum logic [1:0] {
		ST_IDLE      = 2'd0,
		ST_READ      = 2'd1,
		ST_ACK       = 2'd2,
		ST_WAIT_DROP = 2'd3
	} lsu_state_t;

endpackage

`default_nettype wire

//--- src/dmem_regs.sv
/*
 * Control and status registers beside the load/store unit.
 * Holds the write-protect boundary, counts refused accesses and keeps
 * the address of the last refused access, behind a four-phase port.
 */
`timescale 1ns/1ns
`default_nettype none

module dmem_regs import dmem_pkg::*; (
	input  wire      clk,
	input  wire      i_arst_n,
	input  wire      i_reg_req,
	input  wire      i_reg_we,
	input  reg_sel_t i_reg_sel,
	input  word_t    i_reg_wdata,
	input  wire      i_fault_pulse,
	input  addr_t    i_fault_addr,
	output logic     o_reg_ack,
	output word_t    o_reg_rdata,
	output addr_t    o_protect_top
);

	word_t fault_cnt;
	addr_t fault_addr;
	logic  acc_start;
	logic  wr_protect;
	logic  wr_fault_cnt;
	word_t rd_mux;

	// A register access takes effect on the edge that raises the ack
	assign acc_start    = i_reg_req && !o_reg_ack;
	assign wr_protect   = acc_start && i_reg_we && (i_reg_sel == REG_PROTECT);
	assign wr_fault_cnt = acc_start && i_reg_we && (i_reg_sel == REG_FAULT_CNT);

	// Four-phase ack
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_reg_ack <= 1'b0;
		end
		else if (acc_start)
		begin
			o_reg_ack <= 1'b1;
		end
		else if (!i_reg_req)
		begin
			o_reg_ack <= 1'b0;
		end
	end

	// Protect boundary, stores below this byte address are refused
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_protect_top <= '0;
		else if (wr_protect)
			o_protect_top <= i_reg_wdata;
	end

	// Fault counter and last fault address
	// A clear through the port wins over a pulse on the same edge
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			fault_cnt  <= '0;
			fault_addr <= '0;
		end
		else
		begin
			if (wr_fault_cnt)
				fault_cnt <= '0;
			else if (i_fault_pulse)
				fault_cnt <= fault_cnt + 32'd1;
			if (i_fault_pulse)
				fault_addr <= i_fault_addr;
		end
	end

	// Read select, unused selects read as zero
	always_comb
	begin
		case (i_reg_sel)
			REG_PROTECT:    rd_mux = o_protect_top;
			REG_FAULT_CNT:  rd_mux = fault_cnt;
			REG_FAULT_ADDR: rd_mux = fault_addr;
			default:        rd_mux = '0;
		endcase
	end

	// Read data is captured with the ack and held while it stays high
	always_ff @(posedge clk)
	begin
		if (acc_start)
			o_reg_rdata <= rd_mux;
	end

	a_reg_ack_needs_req: assert property (
		@(posedge clk) disable iff (!i_arst_n) $rose(o_reg_ack) |-> $past(i_reg_req)
	) else $error("dmem_regs: o_reg_ack rose without a request");

endmodule

`default_nettype wire

//--- src/dmem_top.sv
/*
 * Data-memory subsystem top level.
 * Connects the load/store unit to the word memory and to the
 * register block that sets its write-protect boundary.
 */
`timescale 1ns/1ns
`default_nettype none

module dmem_top import dmem_pkg::*; #(
	parameter int MEM_WORDS = 256
) (
	input  wire       clk,
	input  wire       i_arst_n,
	input  wire       i_req,
	input  wire       i_we,
	input  acc_size_t i_size,
	input  wire       i_unsigned,
	input  addr_t     i_addr,
	input  word_t     i_wdata,
	input  wire       i_reg_req,
	input  wire       i_reg_we,
	input  reg_sel_t  i_reg_sel,
	input  word_t     i_reg_wdata,
	output logic      o_ack,
	output logic      o_fault,
	output word_t     o_rdata,
	output logic      o_reg_ack,
	output word_t     o_reg_rdata
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	// Memory side of the load/store unit
	byte_en_t         mem_we;
	logic [IDX_W-1:0] mem_addr;
	word_t            mem_wdata;
	word_t            mem_rdata;

	// Steering and fault reporting between the unit and the registers
	addr_t protect_top;
	logic  fault_pulse;
	addr_t fault_addr;

	lsu #(.MEM_WORDS(MEM_WORDS)) u_lsu (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_req(i_req), .i_we(i_we), .i_size(i_size), .i_unsigned(i_unsigned),
		.i_addr(i_addr), .i_wdata(i_wdata),
		.i_mem_rdata(mem_rdata), .i_protect_top(protect_top),
		.o_ack(o_ack), .o_fault(o_fault), .o_rdata(o_rdata),
		.o_mem_we(mem_we), .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata),
		.o_fault_pulse(fault_pulse), .o_fault_addr(fault_addr)
	);

	data_mem #(.MEM_WORDS(MEM_WORDS)) u_data_mem (
		.clk(clk), .i_we(mem_we), .i_addr(mem_addr),
		.i_wdata(mem_wdata), .o_rdata(mem_rdata)
	);

	dmem_regs u_dmem_regs (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_reg_req(i_reg_req), .i_reg_we(i_reg_we), .i_reg_sel(i_reg_sel),
		.i_reg_wdata(i_reg_wdata),
		.i_fault_pulse(fault_pulse), .i_fault_addr(fault_addr),
		.o_reg_ack(o_reg_ack), .o_reg_rdata(o_reg_rdata),
		.o_protect_top(protect_top)
	);

endmodule

`default_nettype wire

//--- src/lsu.sv
/*
 * Load/store unit.
 * Serves one four-phase request at a time from the processor port.
 * Checks alignment, range and write protection, places store bytes on
 * their lanes and extends load data to a full word.
 * Timing: request seen at edge N, memory written and read at N+1,
 * o_ack high after N+2 and held until the request drops.
 */
`timescale 1ns/1ns
`default_nettype none

module lsu import dmem_pkg::*; #(
	parameter int MEM_WORDS = 256
) (
	input  wire                         clk,
	input  wire                         i_arst_n,
	input  wire                         i_req,
	input  wire                         i_we,
	input  acc_size_t                   i_size,
	input  wire                         i_unsigned,
	input  addr_t                       i_addr,
	input  word_t                       i_wdata,
	input  word_t                       i_mem_rdata,
	input  addr_t                       i_protect_top,
	output logic                        o_ack,
	output logic                        o_fault,
	output word_t                       o_rdata,
	output byte_en_t                    o_mem_we,
	output logic [$clog2(MEM_WORDS)-1:0] o_mem_addr,
	output word_t                       o_mem_wdata,
	output logic                        o_fault_pulse,
	output addr_t                       o_fault_addr
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam logic [32:0] MEM_BYTES = 33'(MEM_WORDS) * 33'd4;

	lsu_state_t state;

	logic [2:0]  acc_bytes;
	logic [32:0] acc_end;
	logic        misaligned;
	logic        out_of_range;
	logic        protected_wr;
	logic        fault;
	byte_en_t    lane_en;
	word_t       lane_data;
	word_t       shifted;
	word_t       load_data;

	// Number of bytes touched by the access
	always_comb
	begin
		case (i_size)
			SIZE_BYTE: acc_bytes = 3'd1;
			SIZE_HALF: acc_bytes = 3'd2;
			default:   acc_bytes = 3'd4;
		endcase
	end

	// The checks work on the held request inputs, so they stay valid
	// from the sampling edge until the ack is raised
	assign acc_end      = {1'b0, i_addr} + 33'(acc_bytes);
	assign out_of_range = acc_end > MEM_BYTES;
	assign protected_wr = i_we && (i_addr < i_protect_top);

	always_comb
	begin
		case (i_size)
			SIZE_BYTE: misaligned = 1'b0;
			SIZE_HALF: misaligned = i_addr[0];
			default:   misaligned = |i_addr[1:0];
		endcase
	end

	assign fault = misaligned || out_of_range || protected_wr;

	// Store lane placement
	// Narrow data is replicated across the word and the enables pick the lanes
	always_comb
	begin
		case (i_size)
			SIZE_BYTE:
			begin
				lane_data = {4{i_wdata[7:0]}};
				lane_en   = byte_en_t'(4'b0001 << i_addr[1:0]);
			end
			SIZE_HALF:
			begin
				lane_data = {2{i_wdata[15:0]}};
				lane_en   = i_addr[1] ? 4'b1100 : 4'b0011;
			end
			default:
			begin
				lane_data = i_wdata;
				lane_en   = 4'b1111;
			end
		endcase
	end

	// The write is issued only in ST_READ, so it lands on edge N+1
	assign o_mem_we    = (state == ST_READ && i_we && !fault) ? lane_en : '0;
	assign o_mem_wdata = lane_data;
	assign o_mem_addr  = i_addr[IDX_W+1:2];

	// Load extraction: move the addressed lane down to bit 0, then extend
	assign shifted = i_mem_rdata >> {i_addr[1:0], 3'b000};

	always_comb
	begin
		case (i_size)
			SIZE_BYTE: load_data = {{24{~i_unsigned & shifted[7]}}, shifted[7:0]};
			SIZE_HALF: load_data = {{16{~i_unsigned & shifted[15]}}, shifted[15:0]};
			default:   load_data = shifted;
		endcase
	end

	// Handshake FSM with the ack, fault flag and fault pulse
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state         <= ST_IDLE;
			o_ack         <= 1'b0;
			o_fault       <= 1'b0;
			o_fault_pulse <= 1'b0;
		end
		else
		begin
			o_fault_pulse <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (i_req)
						state <= ST_READ;
				end
				ST_READ:
				begin
					// Fault reported to the register block exactly once per access
					o_fault_pulse <= fault;
					state         <= ST_ACK;
				end
				ST_ACK:
				begin
					o_ack   <= 1'b1;
					o_fault <= fault;
					state   <= ST_WAIT_DROP;
				end
				default:
				begin
					// Back-pressure, everything holds until the request drops
					if (!i_req)
					begin
						o_ack   <= 1'b0;
						o_fault <= 1'b0;
						state   <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Response data and fault address
	always_ff @(posedge clk)
	begin
		if (state == ST_ACK)
			o_rdata <= fault ? '0 : load_data;
		if (state == ST_READ)
			o_fault_addr <= i_addr;
	end

	a_ack_needs_req: assert property (
		@(posedge clk) disable iff (!i_arst_n) $rose(o_ack) |-> $past(i_req)
	) else $error("lsu: o_ack rose without a request");

	// The fault flag shows up two edges after the ST_READ cycle of the same
	// access, and that cycle must not have written any lane
	a_no_write_on_fault: assert property (
		@(posedge clk) disable iff (!i_arst_n) $rose(o_fault) |-> ($past(o_mem_we, 2) == '0)
	) else $error("lsu: memory write while a fault is reported");

endmodule

`default_nettype wire
